// File: common/rv_backend_params.svh
`ifndef RV_BACKEND_PARAMS_SVH
`define RV_BACKEND_PARAMS_SVH

// Integer register and datapath width
`define RV_XLEN 32

// Issue buffer depth
// Also the credit count the upstream holds after reset
`define RV_CREDITS 4

// Data memory size in 32-bit words
`define RV_DMEM_WORDS 256

// MEM/WB stage build
// 1 gives a real register, 0 gives straight wires
`define RV_MEM_WB_REG 1

`endif

// File: common/rv_backend_pkg.sv
`default_nettype none

`include "rv_backend_params.svh"

package rv_backend_pkg;

    // Writeback result source
    typedef enum logic [2:0] {
        RES_ALU  = 3'd0,
        RES_LOAD = 3'd1,
        RES_PC4  = 3'd2,
        RES_JB   = 3'd3,
        RES_CSR  = 3'd4
    } res_src_e;

    // Load/store access size
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Executed instruction as handed over by the execute stage
    typedef struct packed {
        logic                reg_write;
        res_src_e            res_src;
        logic                mem_read;
        logic                mem_write;
        mem_size_e           mem_size;
        logic                load_unsigned;
        logic [4:0]          rd;
        logic [31:0]         instr;
        // Doubles as the byte address for loads and stores
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] store_data;
        logic [`RV_XLEN-1:0] pc_plus4;
        logic [`RV_XLEN-1:0] jb_target;
        logic [`RV_XLEN-1:0] csr_rdata;
    } ex_mem_t;

    // Memory to writeback record
    typedef struct packed {
        logic                reg_write;
        res_src_e            res_src;
        logic [31:0]         instr;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] dmem_rdata_ext;
        logic [`RV_XLEN-1:0] pc_plus4;
        logic [`RV_XLEN-1:0] jb_target;
        logic [`RV_XLEN-1:0] csr_rdata;
    } mem_wb_t;

    // Retired instruction
    typedef struct packed {
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wdata;
        logic [31:0]         instr;
    } commit_t;

    // Data memory request, word addressed
    typedef struct packed {
        logic                we;
        logic [`RV_XLEN-3:0] addr;
        logic [3:0]          be;
        logic [`RV_XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: hdl/rv_stage_reg.sv
`default_nettype none

module rv_stage_reg #(
    parameter type T   = logic,
    parameter int  REG = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    if (REG != 0) begin : g_registered
        // Valid bit is control state and clears on reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                out_valid <= 1'b0;
            end else begin
                out_valid <= in_valid;
            end
        end

        // Payload just follows the input
        always_ff @(posedge clk) begin
            out_data <= in_data;
        end
    end else begin : g_passthrough
        // Stage collapsed into wires
        assign out_valid = in_valid;
        assign out_data  = in_data;
    end

endmodule

`default_nettype wire

// File: hdl/rv_issue_fifo.sv
`default_nettype none

`include "rv_backend_params.svh"

module rv_issue_fifo import rv_backend_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  ex_mem_t in_data,
    output logic    head_valid,
    output ex_mem_t head_data,
    input  logic    pop,
    output logic    credit_return
);

    localparam int DEPTH = `RV_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    ex_mem_t         entries [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_pop;

    // Credits guarantee a free slot for every push
    assign head_valid = (count != '0);
    assign head_data  = entries[rd_ptr];
    assign do_pop     = pop & head_valid;

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (in_valid) begin
            entries[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            end
            // Push and pop together leave the count alone
            case ({in_valid, do_pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: count <= count;
            endcase
            // One credit back per entry that left
            credit_return <= do_pop;
        end
    end

endmodule

`default_nettype wire

// File: mem/rv_lsu.sv
`default_nettype none

module rv_lsu import rv_backend_pkg::*; (
    input  logic        head_valid,
    input  ex_mem_t     head_data,
    output logic        pop,
    output logic        lsu_req_valid,
    output dmem_req_t   lsu_req,
    input  logic        lsu_gnt,
    input  logic [31:0] dmem_rdata,
    output logic        mem_valid,
    output mem_wb_t     mem_data
);

    logic        is_mem;
    logic [1:0]  byte_off;
    logic [31:0] lane;
    logic [31:0] load_ext;
    logic        sign_ext;

    assign is_mem   = head_data.mem_read | head_data.mem_write;
    assign byte_off = head_data.alu_result[1:0];
    assign sign_ext = ~head_data.load_unsigned;

    // Only loads and stores need the memory port
    assign lsu_req_valid = head_valid & is_mem;

    // ALU-only entries leave at once, accesses wait for the grant
    assign pop       = head_valid & (~is_mem | lsu_gnt);
    assign mem_valid = pop;

    // Request forming
    always_comb begin
        lsu_req.we   = head_data.mem_write;
        lsu_req.addr = head_data.alu_result[31:2];
        case (head_data.mem_size)
            MEM_BYTE: begin
                lsu_req.be    = 4'b0001 << byte_off;
                lsu_req.wdata = {4{head_data.store_data[7:0]}};
            end
            MEM_HALF: begin
                lsu_req.be    = 4'b0011 << byte_off;
                lsu_req.wdata = {2{head_data.store_data[15:0]}};
            end
            default: begin
                lsu_req.be    = 4'b1111;
                lsu_req.wdata = head_data.store_data;
            end
        endcase
    end

    // Move the addressed lane down to bit 0
    assign lane = dmem_rdata >> {byte_off, 3'b000};

    // Sign or zero extension
    always_comb begin
        case (head_data.mem_size)
            MEM_BYTE: load_ext = {{24{sign_ext & lane[7]}}, lane[7:0]};
            MEM_HALF: load_ext = {{16{sign_ext & lane[15]}}, lane[15:0]};
            default:  load_ext = lane;
        endcase
    end

    // Record for the MEM/WB register
    always_comb begin
        mem_data.reg_write      = head_data.reg_write;
        mem_data.res_src        = head_data.res_src;
        mem_data.instr          = head_data.instr;
        mem_data.rd             = head_data.rd;
        mem_data.alu_result     = head_data.alu_result;
        mem_data.dmem_rdata_ext = load_ext;
        mem_data.pc_plus4       = head_data.pc_plus4;
        mem_data.jb_target      = head_data.jb_target;
        mem_data.csr_rdata      = head_data.csr_rdata;
    end

endmodule

`default_nettype wire

// File: mem/rv_dmem_arbiter.sv
`default_nettype none

module rv_dmem_arbiter import rv_backend_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        lsu_req_valid,
    input  dmem_req_t   lsu_req,
    output logic        lsu_gnt,
    input  logic        host_req,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    output logic        host_gnt,
    output logic        mem_en,
    output dmem_req_t   mem_req
);

    // Set when the host wins the next tie
    logic host_prio;

    // Grant is combinational, a tie goes to whoever has priority
    always_comb begin
        lsu_gnt  = 1'b0;
        host_gnt = 1'b0;
        if (lsu_req_valid && host_req) begin
            host_gnt = host_prio;
            lsu_gnt  = ~host_prio;
        end else begin
            lsu_gnt  = lsu_req_valid;
            host_gnt = host_req;
        end
    end

    // Priority moves away from the last winner
    // LSU goes first after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_prio <= 1'b0;
        end else if (lsu_gnt) begin
            host_prio <= 1'b1;
        end else if (host_gnt) begin
            host_prio <= 1'b0;
        end
    end

    assign mem_en = lsu_gnt | host_gnt;

    // Host always writes full words
    always_comb begin
        if (host_gnt) begin
            mem_req.we    = host_we;
            mem_req.addr  = host_addr[29:0];
            mem_req.be    = 4'b1111;
            mem_req.wdata = host_wdata;
        end else begin
            mem_req = lsu_req;
        end
    end

endmodule

`default_nettype wire

// File: mem/rv_dmem.sv
`default_nettype none

`include "rv_backend_params.svh"

module rv_dmem import rv_backend_pkg::*; (
    input  logic        clk,
    input  logic        mem_en,
    input  dmem_req_t   mem_req,
    output logic [31:0] rdata
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    logic [31:0]   mem [`RV_DMEM_WORDS];
    logic [AW-1:0] idx;

    // Word index wraps inside the array
    assign idx = mem_req.addr[AW-1:0];

    // Read path has no enable and no latency
    assign rdata = mem[idx];

    // Byte lanes written at the edge
    always_ff @(posedge clk) begin
        if (mem_en && mem_req.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.be[b]) begin
                    mem[idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv_writeback.sv
`default_nettype none

module rv_writeback import rv_backend_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_valid,
    input  mem_wb_t     wb_data,
    input  logic [4:0]  reg_raddr,
    output logic [31:0] reg_rdata,
    output logic        commit_valid,
    output commit_t     commit_data
);

    logic [31:0] regs [1:31];
    logic [31:0] result;
    logic        rf_we;

    // Result mux
    always_comb begin
        case (wb_data.res_src)
            RES_LOAD: result = wb_data.dmem_rdata_ext;
            RES_PC4:  result = wb_data.pc_plus4;
            RES_JB:   result = wb_data.jb_target;
            RES_CSR:  result = wb_data.csr_rdata;
            default:  result = wb_data.alu_result;
        endcase
    end

    // x0 is never stored, no writes while in reset
    assign rf_we = rst_n & wb_valid & wb_data.reg_write & (wb_data.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[wb_data.rd] <= result;
        end
    end

    // Read port for decode, x0 hardwired
    assign reg_rdata = (reg_raddr == 5'd0) ? 32'd0 : regs[reg_raddr];

    // Every valid instruction retires
    // including ones that do not write a register
    assign commit_valid      = wb_valid;
    assign commit_data.rd    = wb_data.rd;
    assign commit_data.wdata = result;
    assign commit_data.instr = wb_data.instr;

endmodule

`default_nettype wire

// File: hdl/rv_backend_top.sv
`default_nettype none

`include "rv_backend_params.svh"

module rv_backend_top import rv_backend_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // Execute stage, credit based
    input  logic        ex_valid,
    input  ex_mem_t     ex_data,
    output logic        credit_return,
    // Host port into data memory
    input  logic        host_req,
    input  logic        host_we,
    input  logic [31:0] host_addr,
    input  logic [31:0] host_wdata,
    output logic [31:0] host_rdata,
    output logic        host_gnt,
    // Register file read port
    input  logic [4:0]  reg_raddr,
    output logic [31:0] reg_rdata,
    // Retire
    output logic        commit_valid,
    output commit_t     commit_data
);

    logic        head_valid;
    ex_mem_t     head_data;
    logic        pop;
    logic        lsu_req_valid;
    dmem_req_t   lsu_req;
    logic        lsu_gnt;
    logic        mem_en;
    dmem_req_t   mem_req;
    logic [31:0] dmem_rdata;
    logic        mem_valid;
    mem_wb_t     mem_data;
    logic        wb_valid;
    mem_wb_t     wb_data;
    logic        wb_commit_valid;
    commit_t     wb_commit_data;

    // Same read data serves host and LSU
    assign host_rdata = dmem_rdata;

    rv_issue_fifo fifo_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (ex_valid),
        .in_data       (ex_data),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .pop           (pop),
        .credit_return (credit_return)
    );

    rv_lsu lsu_i (
        .head_valid    (head_valid),
        .head_data     (head_data),
        .pop           (pop),
        .lsu_req_valid (lsu_req_valid),
        .lsu_req       (lsu_req),
        .lsu_gnt       (lsu_gnt),
        .dmem_rdata    (dmem_rdata),
        .mem_valid     (mem_valid),
        .mem_data      (mem_data)
    );

    rv_dmem_arbiter arb_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .lsu_req_valid (lsu_req_valid),
        .lsu_req       (lsu_req),
        .lsu_gnt       (lsu_gnt),
        .host_req      (host_req),
        .host_we       (host_we),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_gnt      (host_gnt),
        .mem_en        (mem_en),
        .mem_req       (mem_req)
    );

    rv_dmem dmem_i (
        .clk     (clk),
        .mem_en  (mem_en),
        .mem_req (mem_req),
        .rdata   (dmem_rdata)
    );

    // MEM/WB boundary, may be built as wires
    rv_stage_reg #(
        .T   (mem_wb_t),
        .REG (`RV_MEM_WB_REG)
    ) mem_wb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (mem_valid),
        .in_data   (mem_data),
        .out_valid (wb_valid),
        .out_data  (wb_data)
    );

    rv_writeback wb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_valid     (wb_valid),
        .wb_data      (wb_data),
        .reg_raddr    (reg_raddr),
        .reg_rdata    (reg_rdata),
        .commit_valid (wb_commit_valid),
        .commit_data  (wb_commit_data)
    );

    // Commit output is always registered
    rv_stage_reg #(
        .T   (commit_t),
        .REG (1)
    ) commit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wb_commit_valid),
        .in_data   (wb_commit_data),
        .out_valid (commit_valid),
        .out_data  (commit_data)
    );

endmodule

`default_nettype wire

// File: verif/rv_backend_tb.sv
`default_nettype none

`include "rv_backend_params.svh"

module rv_backend_tb import rv_backend_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Instructions sent per test
    localparam int N_RESULT = 10;
    localparam int N_MEMORY = 48;
    localparam int N_CREDIT = 40;
    localparam int N_HOST   = 32;
    localparam int N_REGS   = 30;
    localparam int N_TOTAL  = N_RESULT + N_MEMORY + N_CREDIT + N_HOST + N_REGS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        ex_valid;
    ex_mem_t     ex_data;
    logic        credit_return;
    logic        host_req;
    logic        host_we;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic [31:0] host_rdata;
    logic        host_gnt;
    logic [4:0]  reg_raddr;
    logic [31:0] reg_rdata;
    logic        commit_valid;
    commit_t     commit_data;

    // Reference state
    logic [31:0] ref_mem [`RV_DMEM_WORDS];
    logic [31:0] ref_regs [32];
    bit          ref_written [32];
    commit_t     exp_q [$];

    // Upstream credit and bookkeeping
    int    credits = `RV_CREDITS;
    int    sent;
    int    returns;
    string test_name = "reset";
    int    test_checks;
    int    test_errs;
    int    total_checks;
    int    total_errs;
    int    tests_run;
    bit    host_stop;

    always #2 clk = ~clk;

    rv_backend_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_data       (ex_data),
        .credit_return (credit_return),
        .host_req      (host_req),
        .host_we       (host_we),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rdata    (host_rdata),
        .host_gnt      (host_gnt),
        .reg_raddr     (reg_raddr),
        .reg_rdata     (reg_rdata),
        .commit_valid  (commit_valid),
        .commit_data   (commit_data)
    );

    // Load extension by access size
    function automatic logic [31:0] extend(logic [31:0] lane, mem_size_e size, logic uns);
        case (size)
            MEM_BYTE: return uns ? {24'd0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
            MEM_HALF: return uns ? {16'd0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
            default:  return lane;
        endcase
    endfunction

    // Expected commit for one record, in program order
    // Also advances the reference memory and register file
    function automatic commit_t model_commit(ex_mem_t r);
        int          w;
        int          off;
        logic [31:0] lane;
        logic [31:0] res;
        commit_t     c;
        w   = int'(r.alu_result[31:2]) % `RV_DMEM_WORDS;
        off = int'(r.alu_result[1:0]);
        if (r.mem_write) begin
            case (r.mem_size)
                MEM_BYTE: ref_mem[w][8*off +: 8]  = r.store_data[7:0];
                MEM_HALF: ref_mem[w][8*off +: 16] = r.store_data[15:0];
                default:  ref_mem[w] = r.store_data;
            endcase
        end
        lane = ref_mem[w] >> (8 * off);
        case (r.res_src)
            RES_LOAD: res = extend(lane, r.mem_size, r.load_unsigned);
            RES_PC4:  res = r.pc_plus4;
            RES_JB:   res = r.jb_target;
            RES_CSR:  res = r.csr_rdata;
            default:  res = r.alu_result;
        endcase
        if (r.reg_write && r.rd != 5'd0) begin
            ref_regs[r.rd]    = res;
            ref_written[r.rd] = 1'b1;
        end
        c.rd    = r.rd;
        c.wdata = res;
        c.instr = r.instr;
        return c;
    endfunction

    // Non-memory record with random payload
    function automatic ex_mem_t rand_alu(res_src_e src);
        ex_mem_t r;
        r            = '0;
        r.reg_write  = 1'b1;
        r.res_src    = src;
        r.mem_size   = MEM_WORD;
        r.rd         = 5'($urandom_range(31, 0));
        r.instr      = $urandom();
        r.alu_result = $urandom();
        r.store_data = $urandom();
        r.pc_plus4   = $urandom();
        r.jb_target  = $urandom();
        r.csr_rdata  = $urandom();
        return r;
    endfunction

    function automatic res_src_e rand_src();
        case ($urandom_range(3, 0))
            0:       return RES_ALU;
            1:       return RES_PC4;
            2:       return RES_JB;
            default: return RES_CSR;
        endcase
    endfunction

    // Aligned load or store to one data word
    function automatic ex_mem_t mem_rec(bit store, mem_size_e size, bit uns, int word);
        ex_mem_t r;
        int      off;
        r = rand_alu(store ? RES_ALU : RES_LOAD);
        case (size)
            MEM_BYTE: off = $urandom_range(3, 0);
            MEM_HALF: off = 2 * $urandom_range(1, 0);
            default:  off = 0;
        endcase
        r.alu_result    = 32'(word * 4 + off);
        r.mem_read      = ~store;
        r.mem_write     = store;
        r.mem_size      = size;
        r.load_unsigned = uns;
        r.reg_write     = ~store;
        return r;
    endfunction

    // Mix of ALU-type records, stores and loads in words 0 to 15
    function automatic ex_mem_t rand_mixed();
        case ($urandom_range(3, 0))
            0:       return mem_rec(1, mem_size_e'($urandom_range(2, 0)), 0,
                                    $urandom_range(15, 0));
            1:       return mem_rec(0, mem_size_e'($urandom_range(2, 0)),
                                    $urandom_range(1, 0), $urandom_range(15, 0));
            default: return rand_alu(rand_src());
        endcase
    endfunction

    task automatic fail(string msg);
        $display("ERROR %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
        test_checks++;
        if (act !== exp) begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            test_errs++;
        end
    endtask

    // Tasks below start and end 1 ns after a rising edge
    task automatic send(ex_mem_t r);
        while (credits == 0) begin
            @(posedge clk);
            #1;
        end
        credits--;
        sent++;
        exp_q.push_back(model_commit(r));
        ex_valid = 1'b1;
        ex_data  = r;
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
    endtask

    // One host access, held until granted
    task automatic host_access(bit we, int word, logic [31:0] wdata);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = word;
        host_wdata = wdata;
        do @(negedge clk); while (!host_gnt);
        if (we) begin
            ref_mem[word] = wdata;
        end else begin
            check_word("host read", ref_mem[word], host_rdata);
        end
        @(posedge clk);
        #1;
        host_req = 1'b0;
    endtask

    task automatic read_reg(int idx, logic [31:0] exp);
        reg_raddr = 5'(idx);
        @(negedge clk);
        check_word($sformatf("x%0d", idx), exp, reg_rdata);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(string name);
        total_checks += test_checks;
        total_errs   += test_errs;
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
    endtask

    task automatic end_test();
        total_checks += test_checks;
        total_errs   += test_errs;
        tests_run++;
        $display("test %-16s checks %4d  errors %0d  %s", test_name, test_checks,
                 test_errs, (test_errs == 0) ? "ok" : "bad");
        test_checks = 0;
        test_errs   = 0;
    endtask

    // Commit comparator, in order against the expected queue
    always @(negedge clk) begin : compare
        commit_t exp;
        if (rst_n && commit_valid) begin
            if (exp_q.size() == 0) begin
                fail("commit arrived with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                test_checks++;
                if (commit_data !== exp) begin
                    $display("FAILED %s: commit expected %h actual %h", test_name, exp,
                             commit_data);
                    test_errs++;
                end
            end
        end
    end

    // Upstream credit counter
    always @(negedge clk) begin
        if (rst_n && credit_return) begin
            returns++;
            if (credits >= `RV_CREDITS) begin
                fail("credit returned while upstream already held all credits");
            end else begin
                credits++;
            end
        end
    end

    initial begin
        repeat (50 * N_TOTAL + 1000) @(posedge clk);
        $display("Watchdog expired in test %s, the run did not finish", test_name);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        ex_mem_t r;
        int      sent0;
        int      ret0;
        void'($urandom(63));
        rst_n      = 1'b0;
        ex_valid   = 1'b0;
        ex_data    = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        reg_raddr  = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Known contents for the load region and the host region
        for (int w = 0; w < 64; w++) begin
            host_access(1, w, $urandom());
        end

        start_test("result_select");
        for (int i = 0; i < 2; i++) begin
            send(rand_alu(RES_ALU));
            send(rand_alu(RES_PC4));
            send(rand_alu(RES_JB));
            send(rand_alu(RES_CSR));
        end
        // Write to x0 still commits
        r    = rand_alu(RES_ALU);
        r.rd = 5'd0;
        send(r);
        send(mem_rec(0, MEM_WORD, 0, 3));
        wait_drain();
        read_reg(0, 32'd0);
        end_test();

        start_test("load_store");
        for (int sz = 0; sz < 3; sz++) begin
            for (int u = 0; u < 2; u++) begin
                for (int k = 0; k < 4; k++) begin
                    int w;
                    w = $urandom_range(15, 0);
                    send(mem_rec(1, mem_size_e'(sz), 0, w));
                    send(mem_rec(0, mem_size_e'(sz), u[0], w));
                end
            end
        end
        wait_drain();
        end_test();

        start_test("credits");
        sent0 = sent;
        ret0  = returns;
        for (int i = 0; i < N_CREDIT; i++) begin
            send(rand_mixed());
        end
        wait_drain();
        check_word("credits after drain", `RV_CREDITS, credits);
        check_word("credit pulses", sent - sent0, returns - ret0);
        end_test();

        // Host works in words 32 to 47, instructions in 0 to 15
        start_test("host_contention");
        host_stop = 1'b0;
        fork
            begin
                while (!host_stop) begin
                    host_access($urandom_range(1, 0), 32 + $urandom_range(15, 0), $urandom());
                end
            end
            begin
                for (int i = 0; i < 24; i++) begin
                    send(rand_mixed());
                end
                wait_drain();
                host_stop = 1'b1;
            end
        join
        for (int i = 0; i < 8; i++) begin
            send(mem_rec(0, MEM_WORD, 0, 32 + 2 * i));
        end
        wait_drain();
        end_test();

        start_test("register_file");
        for (int i = 0; i < N_REGS; i++) begin
            send(rand_mixed());
        end
        wait_drain();
        for (int i = 0; i < 32; i++) begin
            if (i == 0) begin
                read_reg(0, 32'd0);
            end else if (ref_written[i]) begin
                read_reg(i, ref_regs[i]);
            end
        end
        end_test();

        $display("tests %0d  checks %0d  errors %0d", tests_run, total_checks, total_errs);
        if (total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_backend.f
+incdir+common
common/rv_backend_pkg.sv
hdl/rv_stage_reg.sv
hdl/rv_issue_fifo.sv
mem/rv_lsu.sv
mem/rv_dmem_arbiter.sv
mem/rv_dmem.sv
hdl/rv_writeback.sv
hdl/rv_backend_top.sv
verif/rv_backend_tb.sv

// File: Bender.yml
package:
  name: rv_backend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rv_backend_pkg.sv
      - hdl/rv_stage_reg.sv
      - hdl/rv_issue_fifo.sv
      - mem/rv_lsu.sv
      - mem/rv_dmem_arbiter.sv
      - mem/rv_dmem.sv
      - hdl/rv_writeback.sv
      - hdl/rv_backend_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/rv_backend_tb.sv
